// ==== sim.f ====
source/sprite_pkg.sv
source/sprite_ram.sv
source/obj_table_wb.sv
source/sprite_line_scan.sv
source/sprite_line_buf.sv
source/sprite_subsys.sv
tests/tb_sprite_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_sprite_subsys -o tb_sprite_subsys \
    && ./obj_dir/tb_sprite_subsys \
    || exit 1

// ==== tests/tb_sprite_subsys.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the sprite line-attribute subsystem
// Fills the object table over Wishbone, starts lines and reads
// the display bank back against a model of the hit rule
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_sprite_subsys
    import sprite_pkg::*;
();

    localparam int obj_aw  = 5;
    localparam int slot_aw = 4;
    localparam int n_obj   = 2**obj_aw;   // Objects in the table
    localparam int n_slot  = 2**slot_aw;  // Entries per line

    logic               clk;
    logic               reset;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [obj_aw-1:0]  wb_adr;
    logic [31:0]        wb_dat_w;
    logic               wb_ack;
    logic               line_start;
    logic [7:0]         line_v;
    logic               scan_busy;
    logic [slot_aw:0]   line_count;
    logic               line_overflow;
    logic [slot_aw-1:0] rd_index;
    line_entry_t        rd_entry;
    logic               rd_valid;

    logic [31:0] lfsr;               // Random state, one step per bit taken
    obj_attr_t   model [n_obj];      // What the host has written so far
    line_entry_t exp_ent [n_slot];   // Expected display entries
    int          exp_count;
    logic        exp_ovf;
    string       test_name;

    sprite_subsys #(
        .obj_aw  (obj_aw),
        .slot_aw (slot_aw)
    ) u_sprite_subsys (
        .clk           (clk),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_ack        (wb_ack),
        .line_start    (line_start),
        .line_v        (line_v),
        .scan_busy     (scan_busy),
        .line_count    (line_count),
        .line_overflow (line_overflow),
        .rd_index      (rd_index),
        .rd_entry      (rd_entry),
        .rd_valid      (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    task automatic step();
        @(posedge clk);
        #10;  // Inputs change and outputs are sampled clear of the edge
    endtask

    task automatic fail_run(input string why);
        $display("Regression failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
            fail_run("stopped at the first mismatch");
        end
    endtask

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = lfsr[0];
            lfsr   = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic wb_cycle(input logic we, input int adr, input logic [31:0] dat);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr[obj_aw-1:0];
        wb_dat_w = dat;
        waited   = 0;
        step();
        while (!wb_ack) begin
            waited++;
            if (waited > 8) fail_run("no Wishbone ack within 8 cycles");
            step();
        end
        wb_cyc = 1'b0;  // Classic cycle ends on the ack
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        step();
        check("ack once", 0, wb_ack);  // A second pulse would answer nothing
    endtask

    task automatic wb_write(input int idx, input obj_attr_t a);
        // Host layout from bit 0 up is y, x, tile, color, flip_x, flip_y, enable
        wb_cycle(1'b1, idx, {2'b10, a.enable, a.flip_y, a.flip_x, a.color, a.tile, a.x, a.y});
        model[idx] = a;
    endtask

    task automatic place_obj(input int idx, input int y, input logic flip_y,
                             input logic enable);
        obj_attr_t a;
        a.y      = 8'(y);
        a.x      = 8'(idx * 7 + 3);  // Distinct fields per object show ordering
        a.tile   = 8'(8'h40 + idx);
        a.color  = 3'(idx);
        a.flip_x = idx[0];
        a.flip_y = flip_y;
        a.enable = enable;
        wb_write(idx, a);
    endtask

    task automatic clear_table();
        for (int i = 0; i < n_obj; i++) begin
            wb_write(i, '0);
        end
    endtask

    task automatic start_line(input int v);
        int waited;
        line_v     = 8'(v);
        line_start = 1'b1;
        step();
        line_start = 1'b0;
        check("busy after start", 1, scan_busy);
        waited = 0;
        while (scan_busy) begin
            waited++;
            if (waited > 60) fail_run("scan_busy stayed high after a line start");
            step();
        end
        repeat (8) step();  // Line starts stay more than 40 cycles apart
    endtask

    task automatic read_slot(input int idx, output line_entry_t ent, output logic valid);
        rd_index = idx[slot_aw-1:0];
        step();  // One cycle of read latency
        ent   = rd_entry;
        valid = rd_valid;
    endtask

    // Reference for line n straight from the hit rule
    task automatic build_expected(input int n);
        logic [7:0]  diff;
        line_entry_t e;
        exp_count = 0;
        exp_ovf   = 1'b0;
        for (int i = 0; i < n_obj; i++) begin
            diff = 8'(n) - model[i].y;  // Distance below the top, mod 256
            if (model[i].enable && diff < 8'(obj_height)) begin
                if (exp_count == n_slot) begin
                    exp_ovf = 1'b1;
                end else begin
                    e.x      = model[i].x;
                    e.tile   = model[i].tile;
                    e.row    = model[i].flip_y ? 4'(obj_height - 1 - diff) : diff[3:0];
                    e.color  = model[i].color;
                    e.flip_x = model[i].flip_x;
                    exp_ent[exp_count] = e;
                    exp_count++;
                end
            end
        end
    endtask

    task automatic verify_display(input int n);
        line_entry_t ent;
        logic        valid;
        build_expected(n);
        check("line_count", exp_count, line_count);
        check("line_overflow", exp_ovf, line_overflow);
        for (int s = 0; s < n_slot; s++) begin
            read_slot(s, ent, valid);
            check($sformatf("slot %0d valid", s), (s < exp_count), valid);
            if (s < exp_count) begin
                check($sformatf("slot %0d entry", s), exp_ent[s], ent);
            end
        end
    endtask

    task automatic show_line(input int n);
        start_line(n - 1);  // Builds line n in its bank
        start_line(n);      // Puts that bank on display
        verify_display(n);
    endtask

    task automatic reset_values();
        test_name = "reset";
        check("scan_busy", 0, scan_busy);
        check("wb_ack", 0, wb_ack);
        check("rd_valid", 0, rd_valid);
        check("line_count", 0, line_count);
        check("line_overflow", 0, line_overflow);
        wb_cycle(1'b0, 5, 32'hffff_ffff);  // Read cycle, ack with nothing stored
    endtask

    task automatic hit_and_row();
        test_name = "hit_row";
        clear_table();
        place_obj(0, 100, 1'b0, 1'b1);  // Row 0
        place_obj(1, 95, 1'b1, 1'b1);   // Row 5 flipped to 10
        place_obj(2, 85, 1'b0, 1'b1);   // Last row of the object
        place_obj(3, 84, 1'b0, 1'b1);   // 16 lines above, no hit
        place_obj(4, 90, 1'b1, 1'b1);
        show_line(100);
        check("hit count", 4, line_count);
    endtask

    task automatic order_and_wrap();
        line_entry_t ent;
        logic        valid;
        test_name = "order_wrap";
        clear_table();
        place_obj(3, 250, 1'b0, 1'b1);  // Wraps past line 255 onto line 4
        place_obj(7, 0, 1'b0, 1'b0);
        place_obj(10, 0, 1'b1, 1'b1);
        place_obj(20, 250, 1'b0, 1'b0);
        place_obj(31, 4, 1'b0, 1'b1);
        wb_cycle(1'b0, 15, 32'h2000_0004);  // Would add an enabled hit on line 4 if stored
        show_line(4);
        check("hit count", 3, line_count);
        read_slot(0, ent, valid);
        check("wrapped row", 10, ent.row);
        check("wrapped tile", 8'h43, ent.tile);
    endtask

    task automatic bank_swap();
        test_name = "ping_pong";
        clear_table();
        place_obj(0, 40, 1'b0, 1'b1);
        start_line(39);
        place_obj(1, 41, 1'b0, 1'b1);  // Only visible from line 41
        start_line(40);
        verify_display(40);            // Scan for 41 is done, 40 still shown
        check("old line count", 1, line_count);
        start_line(41);
        verify_display(41);
        check("new line count", 2, line_count);
    endtask

    task automatic slot_overflow();
        test_name = "overflow";
        clear_table();
        for (int i = 0; i < 20; i++) begin
            place_obj(i, 60 - i % 8, i[1], 1'b1);
        end
        show_line(60);
        check("full count", n_slot, line_count);
        check("overflow set", 1, line_overflow);
        place_obj(20, 95, 1'b0, 1'b1);
        show_line(100);
        check("overflow cleared", 0, line_overflow);
        check("single hit", 1, line_count);
    endtask

    task automatic random_table();
        obj_attr_t a;
        test_name = "random";
        for (int i = 0; i < n_obj; i++) begin
            a.y      = 8'(96 + rand_bits(5));  // Crowded around the tested lines
            a.x      = 8'(rand_bits(8));
            a.tile   = 8'(rand_bits(8));
            a.color  = 3'(rand_bits(3));
            a.flip_x = rand_bits(1) != 0;
            a.flip_y = rand_bits(1) != 0;
            a.enable = rand_bits(2) != 0;
            wb_write(i, a);
        end
        start_line(109);
        for (int n = 110; n < 118; n++) begin
            start_line(n);
            verify_display(n);
        end
    endtask

    initial begin
        lfsr       = 32'h44c2ced1;
        test_name  = "init";
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        line_start = 1'b0;
        line_v     = '0;
        rd_index   = '0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        step();
        reset_values();
        hit_and_row();
        order_and_wrap();
        bank_swap();
        slot_overflow();
        random_table();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/sprite_subsys.sv ====
////////////////////////////////////////////////////////////
// Sprite line-attribute subsystem top level
// Host table port, per-line scanner and ping-pong line buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sprite_subsys
    import sprite_pkg::*;
#(
    parameter int obj_aw  = 5,  // 32 objects
    parameter int slot_aw = 4   // 16 entries per line
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wb_cyc,
    input  wire logic                   wb_stb,
    input  wire logic                   wb_we,
    input  wire logic [obj_aw-1:0]      wb_adr,
    input  wire logic [31:0]            wb_dat_w,
    output      logic                   wb_ack,
    input  wire logic                   line_start,
    input  wire logic [coord_width-1:0] line_v,
    output      logic                   scan_busy,
    output      logic [slot_aw:0]       line_count,
    output      logic                   line_overflow,
    input  wire logic [slot_aw-1:0]     rd_index,
    output      line_entry_t            rd_entry,
    output      logic                   rd_valid
);

    logic              obj_we;
    logic [obj_aw-1:0] obj_waddr;
    obj_attr_t         obj_wdata;
    logic [obj_aw-1:0] obj_raddr;
    obj_attr_t         obj_rdata;

    logic               ent_we;
    logic [slot_aw-1:0] ent_slot;
    line_entry_t        ent_data;
    logic               wr_bank;
    logic               scan_done;
    logic               scan_ovf;
    logic [slot_aw:0]   ent_count;

    obj_table_wb #(
        .obj_aw (obj_aw)
    ) u_obj_table_wb (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .obj_we   (obj_we),
        .obj_addr (obj_waddr),
        .obj_data (obj_wdata)
    );

    sprite_ram #(
        .payload_t (obj_attr_t),
        .aw        (obj_aw)
    ) u_obj_ram (
        .clk   (clk),
        .we    (obj_we),
        .waddr (obj_waddr),
        .wdata (obj_wdata),
        .raddr (obj_raddr),  // Owned by the scanner
        .rdata (obj_rdata)
    );

    sprite_line_scan #(
        .obj_aw  (obj_aw),
        .slot_aw (slot_aw)
    ) u_sprite_line_scan (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .line_v     (line_v),
        .obj_raddr  (obj_raddr),
        .obj_rdata  (obj_rdata),
        .scan_busy  (scan_busy),
        .ent_we     (ent_we),
        .ent_slot   (ent_slot),
        .ent_data   (ent_data),
        .wr_bank    (wr_bank),
        .scan_done  (scan_done),
        .scan_ovf   (scan_ovf),
        .ent_count  (ent_count)
    );

    sprite_line_buf #(
        .slot_aw (slot_aw)
    ) u_sprite_line_buf (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .disp_bank     (line_v[0]),  // Line parity picks the display bank
        .ent_we        (ent_we),
        .ent_slot      (ent_slot),
        .ent_data      (ent_data),
        .wr_bank       (wr_bank),
        .scan_done     (scan_done),
        .scan_ovf      (scan_ovf),
        .ent_count     (ent_count),
        .rd_index      (rd_index),
        .rd_entry      (rd_entry),
        .rd_valid      (rd_valid),
        .line_count    (line_count),
        .line_overflow (line_overflow)
    );

endmodule

`default_nettype wire

// ==== source/sprite_line_buf.sv ====
////////////////////////////////////////////////////////////
// Ping-pong line buffer for sprite line entries
// The scanner fills one bank while the display reads the other
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sprite_line_buf
    import sprite_pkg::*;
#(
    parameter int slot_aw = 4  // Slot address width
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               line_start,
    input  wire logic               disp_bank,     // Parity of the line being started
    input  wire logic               ent_we,
    input  wire logic [slot_aw-1:0] ent_slot,
    input  wire line_entry_t        ent_data,
    input  wire logic               wr_bank,
    input  wire logic               scan_done,
    input  wire logic               scan_ovf,
    input  wire logic [slot_aw:0]   ent_count,
    input  wire logic [slot_aw-1:0] rd_index,
    output      line_entry_t        rd_entry,      // One cycle after rd_index
    output      logic               rd_valid,
    output      logic [slot_aw:0]   line_count,
    output      logic               line_overflow
);

    logic             disp_sel;           // Bank on display for the current line
    logic             rd_bank;            // disp_sel as seen by the RAM read in flight
    logic [slot_aw:0] bank_count [2];     // Entries held per bank
    logic             bank_ovf   [2];     // Some hits did not fit
    line_entry_t      bank_rdata [2];

    for (genvar b = 0; b < 2; b++) begin : g_bank
        sprite_ram #(
            .payload_t (line_entry_t),
            .aw        (slot_aw)
        ) u_ram (
            .clk   (clk),
            .we    (ent_we && (wr_bank == 1'(b))),  // Only the bank being filled
            .waddr (ent_slot),
            .wdata (ent_data),
            .raddr (rd_index),
            .rdata (bank_rdata[b])
        );
    end

    assign line_count    = bank_count[disp_sel];
    assign line_overflow = bank_ovf[disp_sel];
    assign rd_entry      = rd_bank ? bank_rdata[1] : bank_rdata[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            disp_sel      <= 1'b0;
            rd_bank       <= 1'b0;
            rd_valid      <= 1'b0;
            bank_count[0] <= '0;
            bank_count[1] <= '0;
            bank_ovf[0]   <= 1'b0;
            bank_ovf[1]   <= 1'b0;
        end else begin
            if (line_start) begin
                disp_sel <= disp_bank;  // Swap happens at every line start
            end
            if (scan_done) begin
                bank_count[wr_bank] <= ent_count;  // Scan result for the next line
                bank_ovf[wr_bank]   <= scan_ovf;
            end
            rd_bank  <= disp_sel;  // Keeps the output mux aligned with the RAM read
            rd_valid <= ({1'b0, rd_index} < line_count);
        end
    end

    // The scanner never writes into the bank the display is reading
    no_write_to_display: assert property (
        @(posedge clk) disable iff (reset) ent_we |-> (wr_bank != disp_sel)
    );

endmodule

`default_nettype wire

// ==== source/sprite_line_scan.sv ====
////////////////////////////////////////////////////////////
// Per-line object scanner
// Walks the object table after line_start and writes the
// objects that cover the next line into the line buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sprite_line_scan
    import sprite_pkg::*;
#(
    parameter int obj_aw  = 5,  // Object index width
    parameter int slot_aw = 4   // Line-buffer slot width
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   line_start,
    input  wire logic [coord_width-1:0] line_v,     // Line about to be displayed
    output      logic [obj_aw-1:0]      obj_raddr,
    input  wire obj_attr_t              obj_rdata,  // Arrives one cycle after obj_raddr
    output      logic                   scan_busy,
    output      logic                   ent_we,
    output      logic [slot_aw-1:0]     ent_slot,
    output      line_entry_t            ent_data,
    output      logic                   wr_bank,
    output      logic                   scan_done,  // Final count and overflow are valid
    output      logic                   scan_ovf,
    output      logic [slot_aw:0]       ent_count   // Saturates at 2**slot_aw
);

    typedef enum logic [1:0] {
        st_idle,   // Waiting for line_start
        st_scan,   // Issuing object addresses
        st_drain,  // Last object still in the RAM read
        st_done    // One cycle of scan_done
    } scan_state_t;

    scan_state_t            state;
    logic                   data_valid;   // obj_rdata belongs to this scan
    logic [coord_width-1:0] target_line;  // Line the entries are built for
    logic [coord_width-1:0] diff;         // Line offset from the object top, mod 256
    logic                   hit;
    logic                   full;

    assign scan_busy = (state != st_idle);
    assign scan_done = (state == st_done);
    assign wr_bank   = target_line[0];        // The bank not on display
    assign full      = ent_count[slot_aw];    // All slots taken
    assign ent_slot  = ent_count[slot_aw-1:0];

    assign diff   = target_line - obj_rdata.y;  // Wraps for objects near the bottom
    assign hit    = obj_rdata.enable && (diff < obj_height);
    assign ent_we = data_valid && hit && !full;  // Later hits are dropped

    always_comb begin
        ent_data.x      = obj_rdata.x;
        ent_data.tile   = obj_rdata.tile;
        ent_data.row    = diff[row_width-1:0] ^ {row_width{obj_rdata.flip_y}};  // Upside down
        ent_data.color  = obj_rdata.color;
        ent_data.flip_x = obj_rdata.flip_x;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            data_valid <= 1'b0;
            obj_raddr  <= '0;
            ent_count  <= '0;
            scan_ovf   <= 1'b0;
        end else begin
            data_valid <= (state == st_scan);  // Address issued now, data next cycle
            case (state)
                st_idle: begin
                    if (line_start) begin
                        state     <= st_scan;
                        obj_raddr <= '0;  // Objects are scanned in table order
                        ent_count <= '0;
                        scan_ovf  <= 1'b0;
                    end
                end
                st_scan: begin
                    obj_raddr <= obj_raddr + 1'b1;
                    if (obj_raddr == {obj_aw{1'b1}}) begin
                        state <= st_drain;
                    end
                end
                st_drain: state <= st_done;
                default:  state <= st_idle;
            endcase
            if (data_valid && hit) begin
                if (full) begin
                    scan_ovf <= 1'b1;  // More objects than slots on this line
                end else begin
                    ent_count <= ent_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start && !scan_busy) begin
            target_line <= line_v + 8'd1;  // Entries are built one line ahead
        end
    end

    // The video timing leaves room for a whole scan between line starts
    no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset) line_start |-> !scan_busy
    );

endmodule

`default_nettype wire

// ==== source/obj_table_wb.sv ====
////////////////////////////////////////////////////////////
// Wishbone classic slave for the object attribute table
// Host writes become object RAM writes; reads only get an ack
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module obj_table_wb
    import sprite_pkg::*;
#(
    parameter int obj_aw = 5  // Object index width
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic              wb_we,
    input  wire logic [obj_aw-1:0] wb_adr,
    input  wire logic [31:0]       wb_dat_w,
    output      logic              wb_ack,
    output      logic              obj_we,    // Goes high together with wb_ack
    output      logic [obj_aw-1:0] obj_addr,
    output      obj_attr_t         obj_data
);

    logic req;  // A strobe that has not been answered yet

    assign req = wb_cyc && wb_stb && !wb_ack;  // The ack cycle itself never counts twice

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            obj_we <= 1'b0;
        end else begin
            wb_ack <= req;           // One cycle after stb, and only for one cycle
            obj_we <= req && wb_we;  // Read cycles leave the table alone
        end
    end

    // Address and word are captured with the request and written while ack is up
    always_ff @(posedge clk) begin
        if (req) begin
            obj_addr <= wb_adr;
            obj_data <= obj_attr_t'(wb_dat_w[$bits(obj_attr_t)-1:0]);  // Top bits unused
        end
    end

    // Every ack answers a strobe seen on the previous clock
    ack_follows_stb: assert property (
        @(posedge clk) disable iff (reset) wb_ack |-> $past(wb_stb)
    );

endmodule

`default_nettype wire

// ==== source/sprite_ram.sv ====
////////////////////////////////////////////////////////////
// Simple dual-port RAM with a registered read port
// Used for the object table and both line-buffer banks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sprite_ram #(
    parameter type payload_t = logic [7:0],  // Stored word type
    parameter int  aw        = 4             // Address width
) (
    input  wire logic          clk,
    input  wire logic          we,     // Write strobe for waddr
    input  wire logic [aw-1:0] waddr,
    input  wire payload_t      wdata,
    input  wire logic [aw-1:0] raddr,
    output      payload_t      rdata   // Valid one cycle after raddr
);

    payload_t mem [2**aw];  // Contents are undefined until written

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // A read of the address being written sees the old word
    end

endmodule

`default_nettype wire

// ==== source/sprite_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types for the sprite line-attribute buffer
// Object table words, compact line entries and their widths
////////////////////////////////////////////////////////////

`default_nettype none

package sprite_pkg;

    localparam int coord_width = 8;  // Screen coordinates and tile codes are one byte
    localparam int tile_width  = 8;
    localparam int color_width = 3;  // Palette select
    localparam int obj_height  = 16; // Every object covers 16 display lines
    localparam int row_width   = 4;  // Enough to index a row inside one object

    // Field order puts y in the low byte so that the host word casts straight in
    typedef struct packed {
        logic                   enable;  // Bit 29 of the host word
        logic                   flip_y;  // Bit 28
        logic                   flip_x;  // Bit 27
        logic [color_width-1:0] color;   // Bits 26:24
        logic [tile_width-1:0]  tile;    // Bits 23:16
        logic [coord_width-1:0] x;       // Bits 15:8
        logic [coord_width-1:0] y;       // Top line of the object, bits 7:0
    } obj_attr_t;

    // What the horizontal drawing stage needs for one object on one line
    typedef struct packed {
        logic [coord_width-1:0] x;       // Left edge of the object
        logic [tile_width-1:0]  tile;
        logic [row_width-1:0]   row;     // Already flipped when flip_y was set
        logic [color_width-1:0] color;
        logic                   flip_x;  // Left to the pixel fetch
    } line_entry_t;

endpackage

`default_nettype wire
